/* src/mem_pkg.sv */
// CPU-side request types for data reads and writes
// and the read length limit

package mem_pkg;

    localparam int MAX_READ_BYTES = 8;          // longest data read

    typedef logic [31:0] addr_t;                // byte address
    typedef logic [3:0]  read_len_t;            // 1 to 8 bytes
    typedef logic [2:0]  write_len_t;           // 1 to 4 bytes
    typedef logic [63:0] read_data_t;           // low byte first
    typedef logic [31:0] write_data_t;          // low byte first

endpackage

/* src/avm_pkg.sv */
// Avalon-MM bus types, read buffer union, link payload widths
// and bus master state codes

package avm_pkg;

    localparam int MAX_READ_BEATS = 3;

    typedef logic [31:0] dword_t;
    typedef logic [29:0] dword_addr_t;          // byte address bits 31..2
    typedef logic [3:0]  byteenable_t;
    typedef logic [2:0]  burstcount_t;
    typedef logic [63:0] burst_data_t;          // beat 0 in low dword

    // filled per beat by the bus master, picked apart per byte by the reader
    typedef union packed {
        dword_t [MAX_READ_BEATS-1:0]          dwords;
        logic [4*MAX_READ_BEATS-1:0][7:0]     bytes;
    } read_buffer_t;

    localparam int RD_REQ_WIDTH = $bits(dword_addr_t) + $bits(burstcount_t);
    localparam int WR_REQ_WIDTH = RD_REQ_WIDTH + 2 * $bits(byteenable_t)
                                  + $bits(burst_data_t);

    // bus master FSM
    localparam logic [1:0] AVM_IDLE      = 2'd0;
    localparam logic [1:0] AVM_WRITE     = 2'd1;
    localparam logic [1:0] AVM_READ_CMD  = 2'd2;
    localparam logic [1:0] AVM_READ_DATA = 2'd3;

endpackage

/* src/mem_link.sv */
// registered request slice between a requester and the bus master
`timescale 1ns/1ps

module mem_link #(
    parameter int REQ_WIDTH = 33
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 req_do,
    output logic                 req_done,
    input  logic [REQ_WIDTH-1:0] req_payload,

    output logic                 resp_do,
    input  logic                 resp_done,
    output logic [REQ_WIDTH-1:0] resp_payload
);

    logic accept;

    // idle when neither flag is set
    assign accept = req_do && !resp_do && !req_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_do  <= 1'b0;
            req_done <= 1'b0;
        end else if (resp_do && resp_done) begin
            resp_do  <= 1'b0;
            req_done <= 1'b1;                   // done back to requester
        end else begin
            resp_do  <= resp_do || accept;
            req_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_payload <= req_payload;
        end
    end

    done_while_forwarding: assert property (@(posedge clk) disable iff (reset)
        resp_done |-> resp_do);

endmodule

/* src/memory_read.sv */
// data read front end
// sizes the read burst and aligns the returned bytes
`timescale 1ns/1ps

module memory_read (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  read_do,
    input  mem_pkg::addr_t        read_address,
    input  mem_pkg::read_len_t    read_length,
    output logic                  read_done,
    output mem_pkg::read_data_t   read_data,

    output logic                  rd_do,
    output avm_pkg::dword_addr_t  rd_address,
    output avm_pkg::burstcount_t  rd_burstcount,
    input  logic                  rd_done,
    input  avm_pkg::read_buffer_t rd_buffer
);

    logic                accept;
    logic [4:0]          span;                  // offset + length, rounded up
    logic [1:0]          offset;
    mem_pkg::read_len_t  length;
    mem_pkg::read_data_t aligned;

    assign accept = read_do && !rd_do && !read_done;
    assign span   = 5'(read_address[1:0]) + 5'(read_length) + 5'd3;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_do     <= 1'b0;
            read_done <= 1'b0;
        end else if (rd_do && rd_done) begin
            rd_do     <= 1'b0;
            read_done <= 1'b1;
        end else begin
            rd_do     <= rd_do || accept;
            read_done <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // request capture and result alignment

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_address    <= read_address[31:2];
            rd_burstcount <= span[4:2];         // dwords touched
            offset        <= read_address[1:0];
            length        <= read_length;
        end
        if (rd_do && rd_done) begin
            read_data <= aligned;
        end
    end

    always_comb begin
        for (int i = 0; i < mem_pkg::MAX_READ_BYTES; i++) begin
            if (i < length) begin
                aligned[8*i +: 8] = rd_buffer.bytes[offset + i];
            end else begin
                aligned[8*i +: 8] = 8'h00;      // past requested length
            end
        end
    end

    read_length_legal: assert property (@(posedge clk) disable iff (reset)
        read_do |-> read_length inside {[1:mem_pkg::MAX_READ_BYTES]});

endmodule

/* src/memory_write.sv */
// data write front end
// builds byte enables and shifted data for one or two beats
`timescale 1ns/1ps

module memory_write (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 write_do,
    input  mem_pkg::addr_t       write_address,
    input  mem_pkg::write_len_t  write_length,
    input  mem_pkg::write_data_t write_data,
    output logic                 write_done,

    output logic                 wr_do,
    output avm_pkg::dword_addr_t wr_address,
    output avm_pkg::burstcount_t wr_burstcount,
    output avm_pkg::byteenable_t wr_byteenable_0,
    output avm_pkg::byteenable_t wr_byteenable_1,
    output avm_pkg::burst_data_t wr_data,
    input  logic                 wr_done
);

    logic        accept;
    logic [3:0]  mask;                          // one bit per written byte
    logic [7:0]  be_shift;
    logic [63:0] data_shift;

    assign accept     = write_do && !wr_do && !write_done;
    assign mask       = 4'((5'd1 << write_length) - 5'd1);
    assign be_shift   = {4'h0, mask} << write_address[1:0];
    assign data_shift = {32'h0, write_data} << {write_address[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_do      <= 1'b0;
            write_done <= 1'b0;
        end else if (wr_do && wr_done) begin
            wr_do      <= 1'b0;
            write_done <= 1'b1;
        end else begin
            wr_do      <= wr_do || accept;
            write_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_address      <= write_address[31:2];
            wr_byteenable_0 <= be_shift[3:0];
            wr_byteenable_1 <= be_shift[7:4];
            wr_data         <= data_shift;
            wr_burstcount   <= (be_shift[7:4] != 4'h0) ? 3'd2 : 3'd1;   // spills over
        end
    end

    first_beat_enabled: assert property (@(posedge clk) disable iff (reset)
        wr_do |-> wr_byteenable_0 != 4'h0);

endmodule

/* src/avalon_mem.sv */
// Avalon-MM burst master for data reads and writes
// write requests win over reads
`timescale 1ns/1ps

module avalon_mem (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  readburst_do,
    input  avm_pkg::dword_addr_t  readburst_address,
    input  avm_pkg::burstcount_t  readburst_burstcount,
    output logic                  readburst_done,
    output avm_pkg::read_buffer_t readburst_data,

    input  logic                  writeburst_do,
    input  avm_pkg::dword_addr_t  writeburst_address,
    input  avm_pkg::burstcount_t  writeburst_burstcount,
    input  avm_pkg::byteenable_t  writeburst_byteenable_0,
    input  avm_pkg::byteenable_t  writeburst_byteenable_1,
    input  avm_pkg::burst_data_t  writeburst_data,
    output logic                  writeburst_done,

    output avm_pkg::dword_addr_t  avm_address,
    output avm_pkg::dword_t       avm_writedata,
    output avm_pkg::byteenable_t  avm_byteenable,
    output avm_pkg::burstcount_t  avm_burstcount,
    output logic                  avm_write,
    output logic                  avm_read,
    input  logic                  avm_waitrequest,
    input  logic                  avm_readdatavalid,
    input  avm_pkg::dword_t       avm_readdata
);

    logic [1:0]                                 state;
    logic [$clog2(avm_pkg::MAX_READ_BEATS)-1:0] beat;
    logic                                       last_beat;
    logic                                       start_write;
    logic                                       start_read;
    logic                                       next_write_beat;
    logic                                       read_beat;

    // a request still high in its done cycle is not taken again
    assign start_write     = state == avm_pkg::AVM_IDLE && writeburst_do && !writeburst_done;
    assign start_read      = state == avm_pkg::AVM_IDLE && !start_write
                             && readburst_do && !readburst_done;
    assign last_beat       = {1'b0, beat} == avm_burstcount - 3'd1;
    assign next_write_beat = state == avm_pkg::AVM_WRITE && !avm_waitrequest && !last_beat;
    assign read_beat       = state == avm_pkg::AVM_READ_DATA && avm_readdatavalid;

    // ------------------------------------------------------------
    // control FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= avm_pkg::AVM_IDLE;
            beat            <= '0;
            avm_read        <= 1'b0;
            avm_write       <= 1'b0;
            readburst_done  <= 1'b0;
            writeburst_done <= 1'b0;
        end else begin
            readburst_done  <= 1'b0;
            writeburst_done <= 1'b0;
            if (start_write || start_read) begin
                beat <= '0;
            end else if (next_write_beat || read_beat) begin
                beat <= beat + 1'b1;
            end
            case (state)
                avm_pkg::AVM_IDLE: begin
                    avm_write <= start_write;
                    avm_read  <= start_read;
                    if (start_write) begin
                        state <= avm_pkg::AVM_WRITE;
                    end else if (start_read) begin
                        state <= avm_pkg::AVM_READ_CMD;
                    end
                end
                avm_pkg::AVM_WRITE: begin
                    if (!avm_waitrequest && last_beat) begin
                        avm_write       <= 1'b0;
                        writeburst_done <= 1'b1;
                        state           <= avm_pkg::AVM_IDLE;
                    end
                end
                avm_pkg::AVM_READ_CMD: begin
                    if (!avm_waitrequest) begin    // command taken
                        avm_read <= 1'b0;
                        state    <= avm_pkg::AVM_READ_DATA;
                    end
                end
                default: begin
                    if (read_beat && last_beat) begin
                        readburst_done <= 1'b1;
                        state          <= avm_pkg::AVM_IDLE;
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // bus payload and read buffer

    always_ff @(posedge clk) begin
        if (start_write) begin
            avm_address    <= writeburst_address;
            avm_burstcount <= writeburst_burstcount;
            avm_byteenable <= writeburst_byteenable_0;
            avm_writedata  <= writeburst_data[31:0];
        end else if (start_read) begin
            avm_address    <= readburst_address;
            avm_burstcount <= readburst_burstcount;
            avm_byteenable <= 4'hf;
        end else if (next_write_beat) begin
            avm_byteenable <= writeburst_byteenable_1;
            avm_writedata  <= writeburst_data[63:32];
        end
        if (read_beat) begin
            readburst_data.dwords[beat] <= avm_readdata;    // held until next read
        end
    end

    outputs_held_on_wait: assert property (@(posedge clk) disable iff (reset)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable({avm_address, avm_writedata, avm_byteenable, avm_burstcount,
                     avm_read, avm_write}));

endmodule

/* src/memory.sv */
// data memory unit top level
// read and write front ends, request links, Avalon burst master
`timescale 1ns/1ps

module memory (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  read_do,
    input  mem_pkg::addr_t        read_address,
    input  mem_pkg::read_len_t    read_length,
    output logic                  read_done,
    output mem_pkg::read_data_t   read_data,

    input  logic                  write_do,
    input  mem_pkg::addr_t        write_address,
    input  mem_pkg::write_len_t   write_length,
    input  mem_pkg::write_data_t  write_data,
    output logic                  write_done,

    output avm_pkg::dword_addr_t  avm_address,
    output avm_pkg::dword_t       avm_writedata,
    output avm_pkg::byteenable_t  avm_byteenable,
    output avm_pkg::burstcount_t  avm_burstcount,
    output logic                  avm_write,
    output logic                  avm_read,
    input  logic                  avm_waitrequest,
    input  logic                  avm_readdatavalid,
    input  avm_pkg::dword_t       avm_readdata
);

    // rd_/wr_ before the links, rb_/wb_ after them
    wire                        rd_do, rd_done, rb_do, rb_done;
    wire avm_pkg::dword_addr_t  rd_address, rb_address;
    wire avm_pkg::burstcount_t  rd_burstcount, rb_burstcount;
    wire avm_pkg::read_buffer_t rb_data;                    // bypasses the link

    wire                        wr_do, wr_done, wb_do, wb_done;
    wire avm_pkg::dword_addr_t  wr_address, wb_address;
    wire avm_pkg::burstcount_t  wr_burstcount, wb_burstcount;
    wire avm_pkg::byteenable_t  wr_byteenable_0, wr_byteenable_1;
    wire avm_pkg::byteenable_t  wb_byteenable_0, wb_byteenable_1;
    wire avm_pkg::burst_data_t  wr_data, wb_data;

    // ------------------------------------------------------------
    // read path

    memory_read i_memory_read (
        .clk            (clk),
        .reset          (reset),
        .read_do        (read_do),
        .read_address   (read_address),
        .read_length    (read_length),
        .read_done      (read_done),
        .read_data      (read_data),
        .rd_do          (rd_do),
        .rd_address     (rd_address),
        .rd_burstcount  (rd_burstcount),
        .rd_done        (rd_done),
        .rd_buffer      (rb_data)
    );

    mem_link #(
        .REQ_WIDTH      (avm_pkg::RD_REQ_WIDTH)
    ) i_read_link (
        .clk            (clk),
        .reset          (reset),
        .req_do         (rd_do),
        .req_done       (rd_done),
        .req_payload    ({rd_address, rd_burstcount}),
        .resp_do        (rb_do),
        .resp_done      (rb_done),
        .resp_payload   ({rb_address, rb_burstcount})
    );

    // ------------------------------------------------------------
    // write path

    memory_write i_memory_write (
        .clk             (clk),
        .reset           (reset),
        .write_do        (write_do),
        .write_address   (write_address),
        .write_length    (write_length),
        .write_data      (write_data),
        .write_done      (write_done),
        .wr_do           (wr_do),
        .wr_address      (wr_address),
        .wr_burstcount   (wr_burstcount),
        .wr_byteenable_0 (wr_byteenable_0),
        .wr_byteenable_1 (wr_byteenable_1),
        .wr_data         (wr_data),
        .wr_done         (wr_done)
    );

    mem_link #(
        .REQ_WIDTH      (avm_pkg::WR_REQ_WIDTH)
    ) i_write_link (
        .clk            (clk),
        .reset          (reset),
        .req_do         (wr_do),
        .req_done       (wr_done),
        .req_payload    ({wr_address, wr_burstcount, wr_byteenable_0, wr_byteenable_1,
                          wr_data}),
        .resp_do        (wb_do),
        .resp_done      (wb_done),
        .resp_payload   ({wb_address, wb_burstcount, wb_byteenable_0, wb_byteenable_1,
                          wb_data})
    );

    // ------------------------------------------------------------
    // bus master

    avalon_mem i_avalon_mem (
        .clk                     (clk),
        .reset                   (reset),
        .readburst_do            (rb_do),
        .readburst_address       (rb_address),
        .readburst_burstcount    (rb_burstcount),
        .readburst_done          (rb_done),
        .readburst_data          (rb_data),
        .writeburst_do           (wb_do),
        .writeburst_address      (wb_address),
        .writeburst_burstcount   (wb_burstcount),
        .writeburst_byteenable_0 (wb_byteenable_0),
        .writeburst_byteenable_1 (wb_byteenable_1),
        .writeburst_data         (wb_data),
        .writeburst_done         (wb_done),
        .avm_address             (avm_address),
        .avm_writedata           (avm_writedata),
        .avm_byteenable          (avm_byteenable),
        .avm_burstcount          (avm_burstcount),
        .avm_write               (avm_write),
        .avm_read                (avm_read),
        .avm_waitrequest         (avm_waitrequest),
        .avm_readdatavalid       (avm_readdatavalid),
        .avm_readdata            (avm_readdata)
    );

endmodule

/* dv/memory_tb.sv */
// testbench for the data memory unit
// Avalon slave model, stimulus table, bus monitor, checks and watchdog
`timescale 1ns/1ps

module memory_tb;

    localparam int NUM_ROWS = 12;
    localparam int OP_READ  = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_BOTH  = 2;                 // read and write raised together

    typedef struct {
        int                   op;
        mem_pkg::addr_t       addr;
        mem_pkg::read_len_t   len;
        mem_pkg::write_data_t wdata;
        mem_pkg::read_data_t  expected;
    } row_t;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 read_do;
    mem_pkg::addr_t       read_address;
    mem_pkg::read_len_t   read_length;
    logic                 read_done;
    mem_pkg::read_data_t  read_data;
    logic                 write_do;
    mem_pkg::addr_t       write_address;
    mem_pkg::write_len_t  write_length;
    mem_pkg::write_data_t write_data;
    logic                 write_done;
    avm_pkg::dword_addr_t avm_address;
    avm_pkg::dword_t      avm_writedata;
    avm_pkg::byteenable_t avm_byteenable;
    avm_pkg::burstcount_t avm_burstcount;
    logic                 avm_write;
    logic                 avm_read;
    logic                 avm_waitrequest;
    logic                 avm_readdatavalid;
    avm_pkg::dword_t      avm_readdata;

    row_t                 rows [NUM_ROWS];
    logic [7:0]           ref_mem [0:255];      // expected memory image
    avm_pkg::dword_t      mem [0:63];           // slave storage
    int                   errors = 0;
    int                   checks = 0;

    // bus monitor record of the current row
    int                   mon_wr_beats;
    avm_pkg::burstcount_t mon_wr_bc;
    avm_pkg::burstcount_t mon_rd_bc;
    avm_pkg::byteenable_t mon_wr_be0;
    avm_pkg::byteenable_t mon_wr_be1;
    logic                 mon_read_after_write;
    logic                 held_check = 1'b0;
    logic [70:0]          held_value;

    always #4 clk = ~clk;

    memory i_dut (.*);

    // ------------------------------------------------------------
    // Avalon slave model

    initial begin : slave
        logic [5:0] rd_addr;
        logic [2:0] rd_left;
        logic [1:0] rd_delay;
        logic [1:0] wr_beat;
        void'($urandom(32'hfedc_895e));
        avm_waitrequest   = 1'b0;
        avm_readdatavalid = 1'b0;
        avm_readdata      = '0;
        rd_left           = '0;
        wr_beat           = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a / 4][8 * (a % 4) +: 8] = 8'(a * 3);
        end
        forever begin
            @(posedge clk);
            avm_readdatavalid <= 1'b0;
            if (!reset) begin
                if (avm_write && !avm_waitrequest) begin
                    for (int b = 0; b < 4; b++) begin
                        if (avm_byteenable[b]) begin
                            mem[6'(avm_address[5:0] + 6'(wr_beat))][8*b +: 8] =
                                avm_writedata[8*b +: 8];
                        end
                    end
                    wr_beat = ({1'b0, wr_beat} + 3'd1 == avm_burstcount) ? 2'd0 : wr_beat + 1;
                end
                if (avm_read && !avm_waitrequest) begin
                    rd_addr  = avm_address[5:0];
                    rd_left  = avm_burstcount;
                    rd_delay = 2'(1 + $urandom % 3);
                end else if (rd_left != 0) begin
                    if (rd_delay > 1) begin
                        rd_delay = rd_delay - 1;
                    end else begin
                        avm_readdatavalid <= 1'b1;
                        avm_readdata      <= mem[rd_addr];
                        rd_addr  = rd_addr + 1;
                        rd_left  = rd_left - 1;
                        rd_delay = 2'(1 + $urandom % 3);    // gap before next beat
                    end
                end
                avm_waitrequest <= ($urandom % 4) == 0;
            end
        end
    end

    // ------------------------------------------------------------
    // bus monitor

    always @(posedge clk) begin
        if (!reset) begin
            if (held_check && held_value !== {avm_address, avm_writedata, avm_byteenable,
                                              avm_burstcount, avm_read, avm_write}) begin
                errors++;
                $display("Avalon outputs changed while waitrequest was high at %0t", $time);
            end
            if (avm_write && !avm_waitrequest) begin
                if (mon_wr_beats == 0) begin
                    mon_wr_bc  = avm_burstcount;
                    mon_wr_be0 = avm_byteenable;
                end else begin
                    mon_wr_be1 = avm_byteenable;
                end
                mon_wr_beats++;
            end
            if (avm_read && !avm_waitrequest) begin
                mon_rd_bc            = avm_burstcount;
                mon_read_after_write = mon_wr_beats != 0;
            end
        end
        held_check = (avm_read || avm_write) && avm_waitrequest;
        held_value = {avm_address, avm_writedata, avm_byteenable, avm_burstcount,
                      avm_read, avm_write};
    end

    // ------------------------------------------------------------
    // stimulus table and expected values

    function automatic void set_row(int i, int op, mem_pkg::addr_t addr,
                                    mem_pkg::read_len_t len, mem_pkg::write_data_t wdata);
        rows[i] = '{op, addr, len, wdata, 64'h0};
    endfunction

    function automatic void load_rows();
        set_row(0,  OP_WRITE, 32'h40, 4'd4, 32'hdead_beef);    // aligned, one beat
        set_row(1,  OP_READ,  32'h40, 4'd4, 32'h0);
        set_row(2,  OP_READ,  32'h13, 4'd8, 32'h0);            // three beats
        set_row(3,  OP_READ,  32'h21, 4'd2, 32'h0);            // zero upper bytes
        set_row(4,  OP_WRITE, 32'h52, 4'd4, 32'h1122_3344);    // split over two beats
        set_row(5,  OP_READ,  32'h50, 4'd8, 32'h0);
        set_row(6,  OP_BOTH,  32'h60, 4'd4, 32'hcafe_f00d);
        set_row(7,  OP_WRITE, 32'h05, 4'd1, 32'h0000_00aa);
        set_row(8,  OP_READ,  32'h03, 4'd6, 32'h0);
        set_row(9,  OP_WRITE, 32'h0b, 4'd3, 32'h0055_6677);
        set_row(10, OP_READ,  32'h08, 4'd8, 32'h0);
        set_row(11, OP_BOTH,  32'h31, 4'd2, 32'h0000_9abc);
    endfunction

    // write goes first in a combined row
    function automatic void fill_expected();
        for (int a = 0; a < 256; a++) begin
            ref_mem[a] = 8'(a * 3);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].op != OP_READ) begin
                for (int k = 0; k < rows[i].len; k++) begin
                    ref_mem[8'(rows[i].addr + k)] = rows[i].wdata[8*k +: 8];
                end
            end
            for (int k = 0; k < mem_pkg::MAX_READ_BYTES; k++) begin
                rows[i].expected[8*k +: 8] = (k < rows[i].len) ?
                                             ref_mem[8'(rows[i].addr + k)] : 8'h00;
            end
        end
    endfunction

    function automatic logic [7:0] expected_enables(row_t r);
        logic [7:0] en;
        en = '0;
        for (int k = 0; k < r.len; k++) begin
            en[r.addr[1:0] + k] = 1'b1;
        end
        return en;
    endfunction

    function automatic avm_pkg::burstcount_t read_beats(row_t r);
        int last_dword;
        last_dword = (int'(r.addr[1:0]) + int'(r.len) - 1) / 4;    // dword of the final byte
        return avm_pkg::burstcount_t'(last_dword + 1);
    endfunction

    // ------------------------------------------------------------
    // compare tasks

    task automatic check_read_data(input string name, input mem_pkg::read_data_t got,
                                   input mem_pkg::read_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_byteenable(input string name, input avm_pkg::byteenable_t got,
                                    input avm_pkg::byteenable_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_burstcount(input string name, input avm_pkg::burstcount_t got,
                                    input avm_pkg::burstcount_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // row driver and checker

    task automatic apply_row(input row_t r, output mem_pkg::read_data_t data);
        logic rd_pend;
        logic wr_pend;
        rd_pend = r.op != OP_WRITE;
        wr_pend = r.op != OP_READ;
        data    = '0;
        @(posedge clk);
        mon_wr_beats         = 0;
        mon_wr_be1           = '0;
        mon_read_after_write = 1'b0;
        read_do       <= rd_pend;
        read_address  <= r.addr;
        read_length   <= r.len;
        write_do      <= wr_pend;
        write_address <= r.addr;
        write_length  <= mem_pkg::write_len_t'(r.len);
        write_data    <= r.wdata;
        while (rd_pend || wr_pend) begin
            @(posedge clk);
            if (rd_pend && read_done) begin
                read_do <= 1'b0;
                data    = read_data;                // valid with the done pulse
                rd_pend = 1'b0;
            end
            if (wr_pend && write_done) begin
                write_do <= 1'b0;
                wr_pend  = 1'b0;
            end
        end
    endtask

    task automatic check_row(input row_t r, input mem_pkg::read_data_t data);
        logic [7:0]           en;
        avm_pkg::burstcount_t wr_bc;
        en    = expected_enables(r);
        wr_bc = (en[7:4] != 4'h0) ? 3'd2 : 3'd1;
        if (r.op != OP_READ) begin
            check_burstcount("avm_burstcount (write)", mon_wr_bc, wr_bc);
            check_burstcount("write beats", avm_pkg::burstcount_t'(mon_wr_beats), wr_bc);
            check_byteenable("avm_byteenable (beat 0)", mon_wr_be0, en[3:0]);
            if (wr_bc == 3'd2) begin
                check_byteenable("avm_byteenable (beat 1)", mon_wr_be1, en[7:4]);
            end
        end
        if (r.op != OP_WRITE) begin
            check_burstcount("avm_burstcount (read)", mon_rd_bc, read_beats(r));
            check_read_data("read_data", data, r.expected);
        end
        if (r.op == OP_BOTH && !mon_read_after_write) begin
            errors++;
            $display("read burst was issued before the write burst at %0t", $time);
        end
    endtask

    // ------------------------------------------------------------
    // main sequence and watchdog

    initial begin : run
        int                  row_errors;
        mem_pkg::read_data_t data;
        reset         = 1'b1;
        read_do       = 1'b0;
        read_address  = '0;
        read_length   = 4'd1;
        write_do      = 1'b0;
        write_address = '0;
        write_length  = 3'd1;
        write_data    = '0;
        load_rows();
        fill_expected();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_errors = errors;
            apply_row(rows[i], data);
            check_row(rows[i], data);
            $display("row %0d op %0d addr %h len %0d: %s", i, rows[i].op, rows[i].addr,
                     rows[i].len, (errors == row_errors) ? "ok" : "errors");
        end
        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_ROWS * 200) @(posedge clk);
        $display("timeout after %0d cycles, a request never completed", NUM_ROWS * 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* memory.f */
src/mem_pkg.sv
src/avm_pkg.sv
src/mem_link.sv
src/memory_read.sv
src/memory_write.sv
src/avalon_mem.sv
src/memory.sv
dv/memory_tb.sv

/* Bender.yml */
package:
  name: memory

sources:
  - src/mem_pkg.sv
  - src/avm_pkg.sv
  - src/mem_link.sv
  - src/memory_read.sv
  - src/memory_write.sv
  - src/avalon_mem.sv
  - src/memory.sv
  - target: test
    files:
      - dv/memory_tb.sv
